// ==== common/isaPkg.sv ====
`default_nettype none

package isaPkg;

    typedef logic [31:0] instrT;
    typedef logic [4:0] regIdxT;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOrr,
        aluEor,
        aluEnor,
        aluLsl,
        aluLsr,
        aluPass
    } aluOpT;

    // Instruction field positions
    localparam int rdHi = 4;
    localparam int rdLo = 0;
    localparam int rnHi = 9;
    localparam int rnLo = 5;
    localparam int rmHi = 20;
    localparam int rmLo = 16;
    localparam int shamtHi = 15;
    localparam int shamtLo = 10;
    localparam int aluImmHi = 21;
    localparam int aluImmLo = 10;
    localparam int dtOffHi = 20;
    localparam int dtOffLo = 12;
    localparam int opHi = 31;
    localparam int opLo = 26;
    localparam int rFuncHi = 25;
    localparam int rFuncLo = 21;
    localparam int iFuncHi = 24;
    localparam int iFuncLo = 22;

    // Opcode groups in the top six bits
    localparam logic [5:0] opGroupR = 6'b001010;
    localparam logic [5:0] opGroupI = 6'b100010;
    localparam logic [5:0] opGroupD = 6'b110100;

    // R-format and D-format functions, bits 25..21
    localparam logic [4:0] funcAdd = 5'b00000;
    localparam logic [4:0] funcAnd = 5'b00010;
    localparam logic [4:0] funcEor = 5'b00100;
    localparam logic [4:0] funcEnor = 5'b00101;
    localparam logic [4:0] funcLsl = 5'b00110;
    localparam logic [4:0] funcLsr = 5'b00111;
    localparam logic [4:0] funcOrr = 5'b01000;
    localparam logic [4:0] funcSub = 5'b01001;
    localparam logic [4:0] funcLdur = 5'b00000;
    localparam logic [4:0] funcStur = 5'b00001;

    // I-format functions, bits 24..22
    localparam logic [2:0] funcAddi = 3'b000;
    localparam logic [2:0] funcAndi = 3'b010;
    localparam logic [2:0] funcEori = 3'b100;
    localparam logic [2:0] funcOrri = 3'b110;
    localparam logic [2:0] funcSubi = 3'b111;

    localparam regIdxT zeroReg = 5'd31;

    // Opcode group zero is unused, so an all-zero word decodes as a NOP
    localparam instrT nopInstr = 32'h0000_0000;

endpackage

`default_nettype wire

// ==== common/pipePkg.sv ====
`default_nettype none

package pipePkg;

    import isaPkg::*;

    typedef logic [63:0] wordT;
    typedef logic [63:0] addrT;

    // Decode to execute
    typedef struct packed {
        wordT opA;
        wordT opB;
        wordT imm;
        logic useImm;
        aluOpT aluOp;
        logic load;
        logic store;
        logic wrEn;
        regIdxT dest;
    } decExT;

    // Execute to memory; result doubles as the data address
    typedef struct packed {
        wordT result;
        wordT storeData;
        logic load;
        logic store;
        logic wrEn;
        regIdxT dest;
    } exMemT;

    // Register file write port
    typedef struct packed {
        logic wrEn;
        regIdxT dest;
        wordT value;
    } wbT;

endpackage

`default_nettype wire

// ==== verilog/fetchStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetchStage #(
    parameter pipePkg::addrT resetPc = '0
) (
    input  wire                clk,
    input  wire                reset,
    input  wire isaPkg::instrT instr,
    output pipePkg::addrT      iAddr,
    output isaPkg::instrT      fetched
);

    import isaPkg::*;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            iAddr <= resetPc;
            fetched <= nopInstr;
        end
        else
        begin
            iAddr <= iAddr + 64'd4;
            fetched <= instr;
        end
    end

    // PC stays on a word boundary
    pcAligned: assert property (@(posedge clk) disable iff (reset)
        iAddr[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== verilog/decodeStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
    input  wire                clk,
    input  wire                reset,
    input  wire isaPkg::instrT fetched,
    output isaPkg::regIdxT     readIdxA,
    output isaPkg::regIdxT     readIdxB,
    input  wire pipePkg::wordT readDataA,
    input  wire pipePkg::wordT readDataB,
    output pipePkg::decExT     toExecute
);

    import isaPkg::*;
    import pipePkg::*;

    logic [5:0] opGroup;
    logic [4:0] rFunc;
    logic [2:0] iFunc;
    regIdxT rd;
    aluOpT aluOp;
    logic known;
    logic useImm;
    logic load;
    logic store;
    logic wrEn;
    wordT imm;

    assign opGroup = fetched[opHi:opLo];
    assign rFunc = fetched[rFuncHi:rFuncLo];
    assign iFunc = fetched[iFuncHi:iFuncLo];
    assign rd = fetched[rdHi:rdLo];

    always_comb
    begin
        aluOp = aluPass;
        known = 1'b0;
        useImm = 1'b0;
        load = 1'b0;
        store = 1'b0;
        imm = '0;
        case (opGroup)
            opGroupR:
            begin
                known = 1'b1;
                imm = {58'd0, fetched[shamtHi:shamtLo]};
                case (rFunc)
                    funcAdd: aluOp = aluAdd;
                    funcSub: aluOp = aluSub;
                    funcAnd: aluOp = aluAnd;
                    funcOrr: aluOp = aluOrr;
                    funcEor: aluOp = aluEor;
                    funcEnor: aluOp = aluEnor;
                    funcLsl:
                    begin
                        aluOp = aluLsl;
                        useImm = 1'b1;
                    end
                    funcLsr:
                    begin
                        aluOp = aluLsr;
                        useImm = 1'b1;
                    end
                    default: known = 1'b0;
                endcase
            end
            opGroupI:
            begin
                known = 1'b1;
                useImm = 1'b1;
                imm = {{52{fetched[aluImmHi]}}, fetched[aluImmHi:aluImmLo]};
                case (iFunc)
                    funcAddi: aluOp = aluAdd;
                    funcSubi: aluOp = aluSub;
                    funcAndi: aluOp = aluAnd;
                    funcOrri: aluOp = aluOrr;
                    funcEori: aluOp = aluEor;
                    default: known = 1'b0;
                endcase
            end
            opGroupD:
            begin
                // Address is base plus signed offset
                aluOp = aluAdd;
                useImm = 1'b1;
                imm = {{55{fetched[dtOffHi]}}, fetched[dtOffHi:dtOffLo]};
                case (rFunc)
                    funcLdur:
                    begin
                        known = 1'b1;
                        load = 1'b1;
                    end
                    funcStur:
                    begin
                        known = 1'b1;
                        store = 1'b1;
                    end
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

    // Stores read their data register through port B
    assign readIdxA = fetched[rnHi:rnLo];
    assign readIdxB = store ? rd : fetched[rmHi:rmLo];

    assign wrEn = known && !store && (rd != zeroReg);

    always_ff @(posedge clk)
    begin
        toExecute.opA <= readDataA;
        toExecute.opB <= readDataB;
        toExecute.imm <= imm;
        toExecute.useImm <= useImm;
        toExecute.aluOp <= aluOp;
        toExecute.dest <= rd;
        if (reset)
        begin
            toExecute.load <= 1'b0;
            toExecute.store <= 1'b0;
            toExecute.wrEn <= 1'b0;
        end
        else
        begin
            toExecute.load <= load;
            toExecute.store <= store;
            toExecute.wrEn <= wrEn;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/regFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  wire                 clk,
    input  wire                 reset,
    input  wire isaPkg::regIdxT readIdxA,
    input  wire isaPkg::regIdxT readIdxB,
    output pipePkg::wordT       readDataA,
    output pipePkg::wordT       readDataB,
    input  wire pipePkg::wbT    writeback
);

    import isaPkg::*;
    import pipePkg::*;

    wordT regOut [0:31];
    logic fwdA;
    logic fwdB;

    genvar i;
    generate
        for (i = 0; i < 31; i++)
        begin : regBank
            wordT q;

            always_ff @(posedge clk)
            begin
                if (reset)
                    q <= '0;
                else if (writeback.wrEn && (writeback.dest == regIdxT'(i)))
                    q <= writeback.value;
            end

            assign regOut[i] = q;
        end
    endgenerate

    // X31 has no storage
    assign regOut[zeroReg] = '0;

    // Write-through so a reader in the write cycle sees the new value
    assign fwdA = writeback.wrEn && (writeback.dest == readIdxA) && (readIdxA != zeroReg);
    assign fwdB = writeback.wrEn && (writeback.dest == readIdxB) && (readIdxB != zeroReg);

    assign readDataA = fwdA ? writeback.value : regOut[readIdxA];
    assign readDataB = fwdB ? writeback.value : regOut[readIdxB];

    // Decode drops writes to X31 three stages upstream
    noZeroWrite: assert property (@(posedge clk) disable iff (reset)
        writeback.wrEn |-> (writeback.dest != zeroReg));

endmodule

`default_nettype wire

// ==== verilog/executeStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module executeStage (
    input  wire                 clk,
    input  wire                 reset,
    input  wire pipePkg::decExT fromDecode,
    output pipePkg::exMemT      toMemory
);

    import isaPkg::*;
    import pipePkg::*;

    wordT operandA;
    wordT operandB;
    wordT result;
    logic [5:0] shamt;

    assign operandA = fromDecode.opA;
    assign operandB = fromDecode.useImm ? fromDecode.imm : fromDecode.opB;

    // Shift distance from the low bits only
    assign shamt = operandB[5:0];

    always_comb
    begin
        case (fromDecode.aluOp)
            aluAdd: result = operandA + operandB;
            aluSub: result = operandA - operandB;
            aluAnd: result = operandA & operandB;
            aluOrr: result = operandA | operandB;
            aluEor: result = operandA ^ operandB;
            aluEnor: result = ~(operandA ^ operandB);
            aluLsl: result = operandA << shamt;
            aluLsr: result = operandA >> shamt;
            aluPass: result = operandB;
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        toMemory.result <= result;
        // Register B, not the immediate, carries store data
        toMemory.storeData <= fromDecode.opB;
        toMemory.dest <= fromDecode.dest;
        if (reset)
        begin
            toMemory.load <= 1'b0;
            toMemory.store <= 1'b0;
            toMemory.wrEn <= 1'b0;
        end
        else
        begin
            toMemory.load <= fromDecode.load;
            toMemory.store <= fromDecode.store;
            toMemory.wrEn <= fromDecode.wrEn;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/memoryStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module memoryStage (
    input  wire                 clk,
    input  wire                 reset,
    input  wire pipePkg::exMemT fromExecute,
    output pipePkg::addrT       dAddr,
    output pipePkg::wordT       storeData,
    output logic                storeEn,
    input  wire pipePkg::wordT  loadData,
    output pipePkg::wbT         writeback
);

    // Data memory sees the stage register directly
    assign dAddr = fromExecute.result;
    assign storeData = fromExecute.storeData;
    assign storeEn = fromExecute.store;

    always_ff @(posedge clk)
    begin
        writeback.value <= fromExecute.load ? loadData : fromExecute.result;
        writeback.dest <= fromExecute.dest;
        if (reset)
            writeback.wrEn <= 1'b0;
        else
            writeback.wrEn <= fromExecute.wrEn;
    end

    // Decode never flags both for one instruction
    loadStoreExclusive: assert property (@(posedge clk) disable iff (reset)
        !(fromExecute.load && fromExecute.store));

endmodule

`default_nettype wire

// ==== verilog/cpuTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuTop #(
    parameter pipePkg::addrT resetPc = '0
) (
    input  wire                clk,
    input  wire                reset,
    input  wire isaPkg::instrT instr,
    output pipePkg::addrT      iAddr,
    output pipePkg::addrT      dAddr,
    output pipePkg::wordT      storeData,
    output logic               storeEn,
    input  wire pipePkg::wordT loadData
);

    import isaPkg::*;
    import pipePkg::*;

    instrT fetched;
    regIdxT readIdxA;
    regIdxT readIdxB;
    wordT readDataA;
    wordT readDataB;
    decExT decToEx;
    exMemT exToMem;
    wbT memToWb;

    fetchStage #(
        .resetPc(resetPc)
    ) fetchStage_i (
        .clk(clk),
        .reset(reset),
        .instr(instr),
        .iAddr(iAddr),
        .fetched(fetched)
    );

    decodeStage decodeStage_i (
        .clk(clk),
        .reset(reset),
        .fetched(fetched),
        .readIdxA(readIdxA),
        .readIdxB(readIdxB),
        .readDataA(readDataA),
        .readDataB(readDataB),
        .toExecute(decToEx)
    );

    regFile regFile_i (
        .clk(clk),
        .reset(reset),
        .readIdxA(readIdxA),
        .readIdxB(readIdxB),
        .readDataA(readDataA),
        .readDataB(readDataB),
        .writeback(memToWb)
    );

    executeStage executeStage_i (
        .clk(clk),
        .reset(reset),
        .fromDecode(decToEx),
        .toMemory(exToMem)
    );

    memoryStage memoryStage_i (
        .clk(clk),
        .reset(reset),
        .fromExecute(exToMem),
        .dAddr(dAddr),
        .storeData(storeData),
        .storeEn(storeEn),
        .loadData(loadData),
        .writeback(memToWb)
    );

endmodule

`default_nettype wire

// ==== bench/cpuTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuTb;

    import isaPkg::*;
    import pipePkg::*;

    // One program slot with the store it should produce
    typedef struct packed {
        instrT instr;
        logic hasStore;
        addrT addr;
        wordT data;
    } rowT;

    logic clk;
    logic reset;
    instrT instr;
    addrT iAddr;
    addrT dAddr;
    wordT storeData;
    logic storeEn;
    wordT loadData;

    instrT imem [0:255];
    wordT dmem [0:63];
    wordT shadowMem [0:63];
    wordT shadow [0:31];
    rowT rows [$];
    logic [31:0] lfsr;
    logic [8:0] nextOff;
    logic rowsReady;
    int errors;
    int badRows;
    int storeCount;
    int expectStores;

    cpuTop #(
        .resetPc(64'd0)
    ) cpuTop_i (
        .clk(clk),
        .reset(reset),
        .instr(instr),
        .iAddr(iAddr),
        .dAddr(dAddr),
        .storeData(storeData),
        .storeEn(storeEn),
        .loadData(loadData)
    );

    // Both memories answer in the same cycle
    assign instr = (iAddr[63:10] == '0) ? imem[iAddr[9:2]] : nopInstr;
    assign loadData = dmem[dAddr[8:3]];

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk)
    begin
        if (!reset && storeEn)
        begin
            dmem[dAddr[8:3]] <= storeData;
            storeCount <= storeCount + 1;
        end
    end

    function automatic wordT fillWord(logic [5:0] idx);
        return {32'hda7a_0000, 26'd0, idx} ^ {idx, 58'd0};
    endfunction

    function automatic logic [63:0] randBits(int n);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'ha300_0000) : (lfsr >> 1);
            r = {r[62:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic wordT aluModel(aluOpT op, wordT a, wordT b);
        case (op)
            aluAdd: return a + b;
            aluSub: return a - b;
            aluAnd: return a & b;
            aluOrr: return a | b;
            aluEor: return a ^ b;
            aluEnor: return ~(a ^ b);
            aluLsl: return a << b[5:0];
            aluLsr: return a >> b[5:0];
            default: return b;
        endcase
    endfunction

    task automatic addRow(instrT word, logic hasStore, addrT addr, wordT data);
        rows.push_back(rowT'{word, hasStore, addr, data});
        if (hasStore)
            expectStores++;
    endtask

    task automatic regOp(aluOpT op, logic [4:0] func, regIdxT rd, regIdxT rn, regIdxT rm,
                         logic [5:0] shamt);
        wordT b;
        b = (op == aluLsl || op == aluLsr) ? {58'd0, shamt} : shadow[rm];
        if (rd != zeroReg)
            shadow[rd] = aluModel(op, shadow[rn], b);
        addRow({opGroupR, func, rm, shamt, rn, rd}, 1'b0, '0, '0);
    endtask

    task automatic immOp(aluOpT op, logic [2:0] func, regIdxT rd, regIdxT rn, logic [11:0] imm);
        if (rd != zeroReg)
            shadow[rd] = aluModel(op, shadow[rn], {{52{imm[11]}}, imm});
        addRow({opGroupI, 1'b0, func, imm, rn, rd}, 1'b0, '0, '0);
    endtask

    task automatic memOp(logic isStore, regIdxT rt, regIdxT rn, logic [8:0] off);
        addrT a;
        instrT word;
        a = shadow[rn] + {{55{off[8]}}, off};
        word = {opGroupD, isStore ? funcStur : funcLdur, off, 2'b00, rn, rt};
        if (isStore)
        begin
            shadowMem[a[8:3]] = shadow[rt];
            addRow(word, 1'b1, a, shadow[rt]);
        end
        else
        begin
            if (rt != zeroReg)
                shadow[rt] = shadowMem[a[8:3]];
            addRow(word, 1'b0, '0, '0);
        end
    endtask

    // Results go to consecutive words above the base in x10
    task automatic storeResult(regIdxT r);
        memOp(1'b1, r, 5'd10, nextOff);
        nextOff = nextOff + 9'd8;
    endtask

    task automatic buildProgram();
        logic [11:0] immA;
        logic [11:0] immB;
        immA = 12'(randBits(12));
        immB = 12'(randBits(12));
        immOp(aluAdd, funcAddi, 5'd10, zeroReg, 12'd256);
        immOp(aluAdd, funcAddi, 5'd1, zeroReg, immA);
        immOp(aluAdd, funcAddi, 5'd2, zeroReg, immB);
        regOp(aluAdd, funcAdd, 5'd3, 5'd1, 5'd2, 6'd0);
        storeResult(5'd3);
        regOp(aluSub, funcSub, 5'd4, 5'd1, 5'd2, 6'd0);
        storeResult(5'd4);
        regOp(aluAnd, funcAnd, 5'd5, 5'd1, 5'd2, 6'd0);
        storeResult(5'd5);
        regOp(aluOrr, funcOrr, 5'd6, 5'd1, 5'd2, 6'd0);
        storeResult(5'd6);
        regOp(aluEor, funcEor, 5'd7, 5'd1, 5'd2, 6'd0);
        storeResult(5'd7);
        regOp(aluEnor, funcEnor, 5'd8, 5'd1, 5'd2, 6'd0);
        storeResult(5'd8);
        // Negative immediates
        immOp(aluAnd, funcAndi, 5'd11, 5'd8, 12'h800 | 12'(randBits(11)));
        storeResult(5'd11);
        immOp(aluOrr, funcOrri, 5'd12, 5'd1, 12'h800 | 12'(randBits(11)));
        storeResult(5'd12);
        immOp(aluEor, funcEori, 5'd13, 5'd3, 12'h800 | 12'(randBits(11)));
        storeResult(5'd13);
        immOp(aluSub, funcSubi, 5'd14, 5'd2, 12'h800 | 12'(randBits(11)));
        storeResult(5'd14);
        regOp(aluLsl, funcLsl, 5'd15, 5'd8, 5'd0, 6'(randBits(6)));
        storeResult(5'd15);
        regOp(aluLsr, funcLsr, 5'd16, 5'd15, 5'd0, 6'(randBits(6)));
        storeResult(5'd16);
        // Round trip through memory at negative offsets
        memOp(1'b1, 5'd16, 5'd10, 9'h1c0);
        immOp(aluAdd, funcAddi, 5'd18, 5'd10, 12'hfd0);
        memOp(1'b0, 5'd19, 5'd18, 9'h1f0);
        memOp(1'b1, 5'd19, 5'd10, 9'h188);
        // X31 ignores writes and reads zero
        immOp(aluAdd, funcAddi, zeroReg, 5'd1, 12'd5);
        regOp(aluAdd, funcAdd, 5'd20, zeroReg, 5'd2, 6'd0);
        storeResult(5'd20);
        storeResult(zeroReg);
        // Unknown opcode aimed at x3 must leave it alone
        addRow({6'b111111, 21'd0, 5'd3}, 1'b0, '0, '0);
        storeResult(5'd3);
    endtask

    task automatic checkAddr(string name, addrT got, addrT exp);
        if (got !== exp)
        begin
            errors++;
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic checkData(string name, wordT got, wordT exp);
        if (got !== exp)
        begin
            errors++;
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic checkStore(string name, int got, int exp);
        if (got != exp)
        begin
            errors++;
            $display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    initial
    begin
        int early;
        int firstErr;
        addrT expectPc;
        reset = 1'b1;
        rowsReady = 1'b0;
        errors = 0;
        badRows = 0;
        storeCount = 0;
        expectStores = 0;
        nextOff = 9'd0;
        lfsr = 32'h34674b44;
        for (int i = 0; i < 32; i++)
            shadow[i] = '0;
        for (int i = 0; i < 64; i++)
        begin
            dmem[i] = fillWord(6'(i));
            shadowMem[i] = fillWord(6'(i));
        end
        for (int i = 0; i < 256; i++)
            imem[i] = nopInstr;
        buildProgram();
        // Two NOPs follow every row
        foreach (rows[k])
            imem[3 * k] = rows[k].instr;
        rowsReady = 1'b1;
        repeat (3) @(negedge clk);
        reset = 1'b0;
        expectPc = '0;
        checkAddr("iAddr", iAddr, expectPc);
        checkStore("storeEn", int'(storeEn), 0);
        foreach (rows[k])
        begin
            firstErr = errors;
            early = 0;
            for (int off = 1; off <= 3; off++)
            begin
                @(negedge clk);
                expectPc = expectPc + 64'd4;
                checkAddr("iAddr", iAddr, expectPc);
                if (off < 3)
                    early += int'(storeEn);
            end
            // Fetch of row k plus three cycles
            checkStore("storeEn", int'(storeEn), int'(rows[k].hasStore));
            checkStore("early storeEn", early, 0);
            if (rows[k].hasStore)
            begin
                checkAddr("dAddr", dAddr, rows[k].addr);
                checkData("storeData", storeData, rows[k].data);
            end
            if (errors != firstErr)
                badRows++;
            $display("row %0d instr %h %s", k, rows[k].instr,
                     (errors == firstErr) ? "ok" : "mismatch");
        end
        @(negedge clk);
        checkStore("store count", storeCount, expectStores);
        $display("%0d rows run, %0d rows failed, %0d check errors",
                 rows.size(), badRows, errors);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

    // Watchdog
    initial
    begin
        wait (rowsReady);
        repeat (rows.size() * 20 + 50) @(posedge clk);
        $display("Timeout after %0d cycles, the test sequence never completed",
                 rows.size() * 20 + 50);
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
common/isaPkg.sv
common/pipePkg.sv
verilog/fetchStage.sv
verilog/decodeStage.sv
verilog/regFile.sv
verilog/executeStage.sv
verilog/memoryStage.sv
verilog/cpuTop.sv
bench/cpuTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the cpuTb simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module cpuTb -f verilog.f -o cpuSim
./obj_dir/cpuSim > sim.log
cat sim.log

if grep -q "Regression failed" sim.log; then
    exit 1
fi
exit 0
